/* common/cam_bist_defs.svh */
// CAM geometry macros
// Configuration register map for the BIST block

`ifndef CAM_BIST_DEFS_SVH
`define CAM_BIST_DEFS_SVH

// ==============================
// Array geometry
// ==============================

// Entry count must stay a multiple of the data width for the compactor
`define CAM_ENTRIES 16
`define CAM_DWIDTH  8
`define CAM_AWIDTH  4

// ==============================
// Configuration registers
// ==============================

// Bit 0 of CTRL starts a run
`define CFG_ADDR_CTRL       2'd0
`define CFG_ADDR_BACKGROUND 2'd1
`define CFG_ADDR_PHASE_MASK 2'd2

`endif

/* common/cam_pkg.sv */
// CAM array request and response types
// Request carries write, search and read fields in one word

`include "cam_bist_defs.svh"

package cam_pkg;

  // Request word, 26 bits
  typedef struct packed {
    logic                   wr_en;
    logic [`CAM_AWIDTH-1:0] wr_addr;
    logic [`CAM_DWIDTH-1:0] wr_data;
    logic                   srch_en;
    logic [`CAM_DWIDTH-1:0] srch_key;
    logic [`CAM_AWIDTH-1:0] rd_addr;
  } cam_req_t;

  // Response, both fields two cycles behind the request
  typedef struct packed {
    logic [`CAM_ENTRIES-1:0] match;
    logic [`CAM_DWIDTH-1:0]  rd_data;
  } cam_rsp_t;

endpackage

/* common/bist_pkg.sv */
// BIST match-select code and FSM states
// BIST control word and status word

`include "cam_bist_defs.svh"

package bist_pkg;

  // Expected match-line pattern selector
  typedef enum logic [1:0] {
    MATCH_ALL       = 2'd0,
    MATCH_SINGLE    = 2'd1,
    MISMATCH_SINGLE = 2'd2,
    MISMATCH_ALL    = 2'd3
  } match_sel_e;

  // Sequencer FSM
  typedef enum logic [3:0] {
    IDLE,
    WR_UNIQUE,
    SRCH_UNIQUE,
    SRCH_ABSENT,
    WR_COMMON,
    SRCH_COMMON,
    HOLE_WR,
    HOLE_SRCH,
    HOLE_RESTORE,
    DRAIN,
    DONE
  } bist_state_e;

  // Sequencer to output handler and checker
  typedef struct packed {
    logic                   cm_mode;
    match_sel_e             match_sel;
    logic [`CAM_AWIDTH-1:0] addr;
    logic                   check;
  } bist_ctrl_t;

  // Run result
  typedef struct packed {
    logic                   done;
    logic                   fail;
    logic [`CAM_AWIDTH-1:0] fail_addr;
    logic [7:0]             fail_cnt;
    logic [7:0]             cmp_cnt;
  } bist_status_t;

endpackage

/* cam/cam_array.sv */
// Behavioral CAM array
// One write port, one search port, one read port
// Match lines and read data leave through two register stages

`timescale 1ns/1ps
`include "cam_bist_defs.svh"

module cam_array (
  input  logic              bist_clk,
  input  logic              reset,
  input  cam_pkg::cam_req_t req,
  output cam_pkg::cam_rsp_t rsp
);

  logic [`CAM_DWIDTH-1:0]  mem [`CAM_ENTRIES];
  logic [`CAM_ENTRIES-1:0] valid;
  logic [`CAM_ENTRIES-1:0] match_now;
  logic [`CAM_ENTRIES-1:0] match_s1;
  logic [`CAM_ENTRIES-1:0] match_s2;
  logic [`CAM_DWIDTH-1:0]  rd_s1;
  logic [`CAM_DWIDTH-1:0]  rd_s2;

  // ==============================
  // Storage
  // ==============================

  // Valid bit set on first write to an entry
  always_ff @(posedge bist_clk) begin
    if (reset) begin
      valid <= '0;
    end else if (req.wr_en) begin
      valid[req.wr_addr] <= 1'b1;
    end
  end

  always_ff @(posedge bist_clk) begin
    if (req.wr_en) begin
      mem[req.wr_addr] <= req.wr_data;
    end
  end

  // ==============================
  // Search and read pipeline
  // ==============================

  // Search sees the contents before a same-cycle write
  always_comb begin
    for (int i = 0; i < `CAM_ENTRIES; i++) begin
      match_now[i] = req.srch_en && valid[i] && (mem[i] == req.srch_key);
    end
  end

  // Idle match lines read as all zero
  always_ff @(posedge bist_clk) begin
    if (reset) begin
      match_s1 <= '0;
      match_s2 <= '0;
    end else begin
      match_s1 <= match_now;
      match_s2 <= match_s1;
    end
  end

  always_ff @(posedge bist_clk) begin
    rd_s1 <= mem[req.rd_addr];
    rd_s2 <= rd_s1;
  end

  assign rsp.match   = match_s2;
  assign rsp.rd_data = rd_s2;

  // Overwriting the entry a search would hit leaves that match line ambiguous
  a_no_wr_srch_collision: assert property (
    @(posedge bist_clk) disable iff (reset)
    req.srch_en |-> !(req.wr_en && valid[req.wr_addr] && (mem[req.wr_addr] == req.srch_key))
  );

endmodule

/* bist/bist_config_regs.sv */
// BIST configuration registers
// Background pattern, phase mask and start pulse decode

`timescale 1ns/1ps
`include "cam_bist_defs.svh"

module bist_config_regs (
  input  logic                   bist_clk,
  input  logic                   reset,
  input  logic                   cfg_wr_en,
  input  logic [1:0]             cfg_addr,
  input  logic [`CAM_DWIDTH-1:0] cfg_wdata,
  output logic                   start,
  output logic [`CAM_DWIDTH-1:0] background,
  output logic [3:0]             phase_mask
);

  // Start is a single-cycle pulse, never held
  always_ff @(posedge bist_clk) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= cfg_wr_en && (cfg_addr == `CFG_ADDR_CTRL) && cfg_wdata[0];
    end
  end

  // Defaults give a full run on an alternating pattern
  always_ff @(posedge bist_clk) begin
    if (reset) begin
      background <= 8'h5A;
      phase_mask <= 4'hF;
    end else if (cfg_wr_en) begin
      if (cfg_addr == `CFG_ADDR_BACKGROUND) begin
        background <= cfg_wdata;
      end
      // Upper nibble ignored
      if (cfg_addr == `CFG_ADDR_PHASE_MASK) begin
        phase_mask <= cfg_wdata[3:0];
      end
    end
  end

endmodule

/* bist/bist_sequencer.sv */
// BIST sequencer FSM
// Runs unique, absent, common and hole phases under a phase mask
// One array operation per cycle, two drain cycles after each phase

`timescale 1ns/1ps
`include "cam_bist_defs.svh"

module bist_sequencer (
  input  logic                   bist_clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic [`CAM_DWIDTH-1:0] background,
  input  logic [3:0]             phase_mask,
  output cam_pkg::cam_req_t      cam_req,
  output bist_pkg::bist_ctrl_t   ctrl,
  output logic                   done
);
  import bist_pkg::*;

  bist_state_e            state;
  match_sel_e             match_sel;
  logic [`CAM_AWIDTH-1:0] addr;
  logic [`CAM_DWIDTH-1:0] addr_ext;
  logic [`CAM_DWIDTH-1:0] bg;
  logic [1:0]             phase;
  logic [1:0]             pick;
  logic [3:0]             mask_left;
  logic                   last_addr;
  logic                   drain_last;
  logic                   chk_d1;
  logic                   chk_d2;

  // Lowest pending phase wins
  function automatic logic [1:0] lowest_phase(input logic [3:0] m);
    logic [1:0] p;
    p = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (m[i]) p = i[1:0];
    end
    return p;
  endfunction

  // Phases 0 and 1 start from unique data, 2 and 3 from common data
  function automatic bist_state_e entry_state(input logic [1:0] p);
    return p[1] ? WR_COMMON : WR_UNIQUE;
  endfunction

  assign pick      = lowest_phase((state == DRAIN) ? mask_left : phase_mask);
  assign last_addr = &addr;
  assign addr_ext  = {{(`CAM_DWIDTH-`CAM_AWIDTH){1'b0}}, addr};

  // Pattern latched at start
  always_ff @(posedge bist_clk) begin
    if (start && (state == IDLE || state == DONE)) begin
      bg <= background;
    end
  end

  // ==============================
  // State transitions
  // ==============================

  always_ff @(posedge bist_clk) begin
    if (reset) begin
      state      <= IDLE;
      match_sel  <= MATCH_ALL;
      addr       <= '0;
      phase      <= '0;
      mask_left  <= '0;
      drain_last <= 1'b0;
      done       <= 1'b0;
    end else begin
      case (state)
        IDLE, DONE: begin
          // Empty mask still drains once and reports done
          if (start) begin
            done <= 1'b0;
            addr <= '0;
            if (phase_mask == 4'd0) begin
              state     <= DRAIN;
              mask_left <= '0;
            end else begin
              state     <= entry_state(pick);
              phase     <= pick;
              mask_left <= phase_mask & ~(4'b0001 << pick);
            end
          end
        end
        WR_UNIQUE: begin
          addr <= addr + 1'b1;
          if (last_addr) begin
            state     <= phase[0] ? SRCH_ABSENT : SRCH_UNIQUE;
            match_sel <= phase[0] ? MISMATCH_ALL : MATCH_SINGLE;
          end
        end
        WR_COMMON: begin
          addr <= addr + 1'b1;
          if (last_addr) begin
            state     <= phase[0] ? HOLE_WR : SRCH_COMMON;
            match_sel <= phase[0] ? MISMATCH_SINGLE : MATCH_ALL;
          end
        end
        SRCH_UNIQUE, SRCH_ABSENT, SRCH_COMMON: begin
          addr <= addr + 1'b1;
          if (last_addr) state <= DRAIN;
        end
        HOLE_WR:   state <= HOLE_SRCH;
        HOLE_SRCH: state <= HOLE_RESTORE;
        HOLE_RESTORE: begin
          addr  <= addr + 1'b1;
          state <= last_addr ? DRAIN : HOLE_WR;
        end
        DRAIN: begin
          // Toggle leaves drain_last clear for the next drain
          drain_last <= ~drain_last;
          if (drain_last) begin
            addr <= '0;
            if (mask_left != 4'd0) begin
              state     <= entry_state(pick);
              phase     <= pick;
              mask_left <= mask_left & ~(4'b0001 << pick);
            end else begin
              state <= DONE;
              done  <= 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ==============================
  // Request and control decode
  // ==============================

  always_comb begin
    cam_req         = '0;
    cam_req.wr_addr = addr;
    cam_req.rd_addr = addr;
    ctrl.cm_mode    = (state != IDLE) && (state != DONE);
    ctrl.match_sel  = match_sel;
    ctrl.addr       = addr;
    ctrl.check      = 1'b0;
    case (state)
      WR_UNIQUE: begin
        cam_req.wr_en   = 1'b1;
        cam_req.wr_data = bg ^ addr_ext;
      end
      SRCH_UNIQUE: begin
        cam_req.srch_en  = 1'b1;
        cam_req.srch_key = bg ^ addr_ext;
        ctrl.check       = 1'b1;
      end
      SRCH_ABSENT: begin
        // Offset by the entry count, outside every unique value
        cam_req.srch_en  = 1'b1;
        cam_req.srch_key = bg ^ (addr_ext + `CAM_DWIDTH'(`CAM_ENTRIES));
        ctrl.check       = 1'b1;
      end
      WR_COMMON, HOLE_RESTORE: begin
        cam_req.wr_en   = 1'b1;
        cam_req.wr_data = bg;
      end
      HOLE_WR: begin
        cam_req.wr_en   = 1'b1;
        cam_req.wr_data = ~bg;
      end
      SRCH_COMMON, HOLE_SRCH: begin
        cam_req.srch_en  = 1'b1;
        cam_req.srch_key = bg;
        ctrl.check       = 1'b1;
      end
      default: ;
    endcase
  end

  // Local copy of the two-cycle check delay
  always_ff @(posedge bist_clk) begin
    if (reset) begin
      chk_d1 <= 1'b0;
      chk_d2 <= 1'b0;
    end else begin
      chk_d1 <= ctrl.check;
      chk_d2 <= chk_d1;
    end
  end

  // Output handler decodes with the live code, so it must hold until the result lands
  a_match_sel_stable: assert property (
    @(posedge bist_clk) disable iff (reset)
    (chk_d1 || chk_d2) |-> $stable(ctrl.match_sel)
  );

endmodule

/* bist/bist_out_handler.sv */
// BIST output handler
// Expected match-vector decode and match-line compare
// Compactor folds the compare vector to read-data width
// Read-data mux selects the folded vector in compare mode

`timescale 1ns/1ps
`include "cam_bist_defs.svh"

module bist_out_handler (
  input  logic                    bist_clk,
  input  bist_pkg::bist_ctrl_t    ctrl,
  input  logic [`CAM_DWIDTH-1:0]  cam_rd_data,
  input  logic [`CAM_ENTRIES-1:0] cam_match,
  output logic [`CAM_DWIDTH-1:0]  rd_data,
  output logic [`CAM_ENTRIES-1:0] cm_match_ref_data
);
  import bist_pkg::*;

  // Match lines per read-data bit
  localparam int FOLD = `CAM_ENTRIES / `CAM_DWIDTH;

  logic [`CAM_AWIDTH-1:0]  addr_d1;
  logic [`CAM_AWIDTH-1:0]  addr_d2;
  logic [`CAM_ENTRIES-1:0] one_hot;
  logic [`CAM_ENTRIES-1:0] expected;
  logic [`CAM_ENTRIES-1:0] compared;
  logic [`CAM_DWIDTH-1:0]  folded;

  // ==============================
  // Expected match vector
  // ==============================

  // Align address with the array's two output stages
  always_ff @(posedge bist_clk) begin
    addr_d1 <= ctrl.addr;
    addr_d2 <= addr_d1;
  end

  assign one_hot = {{(`CAM_ENTRIES-1){1'b0}}, 1'b1} << addr_d2;

  always_comb begin
    unique case (ctrl.match_sel)
      MATCH_ALL:       expected = '1;
      MATCH_SINGLE:    expected = one_hot;
      MISMATCH_SINGLE: expected = ~one_hot;
      MISMATCH_ALL:    expected = '0;
      default:         expected = '0;
    endcase
  end

  assign cm_match_ref_data = expected;

  // ==============================
  // Compare and compact
  // ==============================

  // Any set bit marks a wrong match line
  assign compared = expected ^ cam_match;

  // Bit i collects lines i, i+DW, i+2*DW ...
  always_comb begin
    folded = '0;
    for (int i = 0; i < `CAM_DWIDTH; i++) begin
      for (int k = 0; k < FOLD; k++) begin
        folded[i] = folded[i] | compared[i + k*`CAM_DWIDTH];
      end
    end
  end

  assign rd_data = ctrl.cm_mode ? folded : cam_rd_data;

endmodule

/* bist/bist_response_checker.sv */
// BIST response checker
// Check strobe alignment, failure detect, first-fail address, counters

`timescale 1ns/1ps
`include "cam_bist_defs.svh"

module bist_response_checker (
  input  logic                   bist_clk,
  input  logic                   reset,
  input  logic                   check,
  input  logic [`CAM_AWIDTH-1:0] check_addr,
  input  logic [`CAM_DWIDTH-1:0] rd_data,
  input  logic                   done,
  output bist_pkg::bist_status_t status
);

  logic                   chk_d1;
  logic                   chk_d2;
  logic [`CAM_AWIDTH-1:0] addr_d1;
  logic [`CAM_AWIDTH-1:0] addr_d2;
  logic                   done_q;
  logic                   fail;
  logic [`CAM_AWIDTH-1:0] fail_addr;
  logic [7:0]             fail_cnt;
  logic [7:0]             cmp_cnt;

  always_ff @(posedge bist_clk) begin
    if (reset) begin
      chk_d1 <= 1'b0;
      chk_d2 <= 1'b0;
    end else begin
      chk_d1 <= check;
      chk_d2 <= chk_d1;
    end
  end

  always_ff @(posedge bist_clk) begin
    addr_d1 <= check_addr;
    addr_d2 <= addr_d1;
  end

  // Falling done means a new run has started, results restart from zero
  always_ff @(posedge bist_clk) begin
    if (reset) begin
      done_q    <= 1'b0;
      fail      <= 1'b0;
      fail_addr <= '0;
      fail_cnt  <= '0;
      cmp_cnt   <= '0;
    end else begin
      done_q <= done;
      if (done_q && !done) begin
        fail      <= 1'b0;
        fail_addr <= '0;
        fail_cnt  <= '0;
        cmp_cnt   <= '0;
      end else if (chk_d2) begin
        cmp_cnt <= cmp_cnt + 8'd1;
        if (|rd_data) begin
          fail     <= 1'b1;
          fail_cnt <= fail_cnt + 8'd1;
          // First failing address only
          if (!fail) fail_addr <= addr_d2;
        end
      end
    end
  end

  always_comb begin
    status.done      = done;
    status.fail      = fail;
    status.fail_addr = fail_addr;
    status.fail_cnt  = fail_cnt;
    status.cmp_cnt   = cmp_cnt;
  end

  // Every compare lands before done is reported, so the results are final
  a_compare_before_done: assert property (
    @(posedge bist_clk) disable iff (reset)
    chk_d2 |-> !done
  );

endmodule

/* source/cam_bist_top.sv */
// CAM with match-line BIST, top level
// Config regs, sequencer, array request mux, array, output handler, checker

`timescale 1ns/1ps
`include "cam_bist_defs.svh"

module cam_bist_top (
  input  logic                    bist_clk,
  input  logic                    reset,
  input  logic                    cfg_wr_en,
  input  logic [1:0]              cfg_addr,
  input  logic [`CAM_DWIDTH-1:0]  cfg_wdata,
  input  cam_pkg::cam_req_t       func_req,
  output logic [`CAM_DWIDTH-1:0]  rd_data,
  output logic [`CAM_ENTRIES-1:0] match_lines,
  output logic [`CAM_ENTRIES-1:0] cm_match_ref_data,
  output bist_pkg::bist_status_t  status
);
  import cam_pkg::*;
  import bist_pkg::*;

  logic                   start;
  logic [`CAM_DWIDTH-1:0] background;
  logic [3:0]             phase_mask;
  logic                   done;
  cam_req_t               bist_req;
  cam_req_t               array_req;
  cam_rsp_t               array_rsp;
  bist_ctrl_t             ctrl;

  bist_config_regs u_cfg (
    .bist_clk   (bist_clk),
    .reset      (reset),
    .cfg_wr_en  (cfg_wr_en),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .start      (start),
    .background (background),
    .phase_mask (phase_mask)
  );

  bist_sequencer u_seq (
    .bist_clk   (bist_clk),
    .reset      (reset),
    .start      (start),
    .background (background),
    .phase_mask (phase_mask),
    .cam_req    (bist_req),
    .ctrl       (ctrl),
    .done       (done)
  );

  // BIST owns the array for the whole run
  assign array_req = ctrl.cm_mode ? bist_req : func_req;

  cam_array u_cam (
    .bist_clk (bist_clk),
    .reset    (reset),
    .req      (array_req),
    .rsp      (array_rsp)
  );

  bist_out_handler u_out (
    .bist_clk          (bist_clk),
    .ctrl              (ctrl),
    .cam_rd_data       (array_rsp.rd_data),
    .cam_match         (array_rsp.match),
    .rd_data           (rd_data),
    .cm_match_ref_data (cm_match_ref_data)
  );

  assign match_lines = array_rsp.match;

  // Checker sees the folded compare vector through rd_data
  bist_response_checker u_chk (
    .bist_clk   (bist_clk),
    .reset      (reset),
    .check      (ctrl.check),
    .check_addr (ctrl.addr),
    .rd_data    (rd_data),
    .done       (done),
    .status     (status)
  );

endmodule

/* testbench/tb_cam_bist.sv */
// Testbench for the CAM match-line BIST top level
// Clock, reset and record-driven stimulus from the input file
// Reference model of the array contents for functional checks
// Error counters, closing summary and watchdog

`timescale 1ns/1ps
`include "cam_bist_defs.svh"

module tb_cam_bist;
  import cam_pkg::*;
  import bist_pkg::*;

  localparam int MAX_RECORDS   = 32;
  localparam int RECORD_CYCLES = 400;

  logic                    bist_clk;
  logic                    reset;
  logic                    cfg_wr_en;
  logic [1:0]              cfg_addr;
  logic [`CAM_DWIDTH-1:0]  cfg_wdata;
  cam_req_t                func_req;
  logic [`CAM_DWIDTH-1:0]  rd_data;
  logic [`CAM_ENTRIES-1:0] match_lines;
  logic [`CAM_ENTRIES-1:0] cm_match_ref_data;
  bist_status_t            status;

  logic [31:0]             records [MAX_RECORDS];
  int                      n_records;
  logic                    loaded;
  logic [15:0]             lfsr;
  logic [`CAM_DWIDTH-1:0]  model_mem [`CAM_ENTRIES];
  logic [`CAM_ENTRIES-1:0] model_known;
  int                      n_checks;
  int                      n_errors;

  // 4 ns period
  initial bist_clk = 1'b0;
  always #2 bist_clk = ~bist_clk;

  cam_bist_top u_dut (
    .bist_clk          (bist_clk),
    .reset             (reset),
    .cfg_wr_en         (cfg_wr_en),
    .cfg_addr          (cfg_addr),
    .cfg_wdata         (cfg_wdata),
    .func_req          (func_req),
    .rd_data           (rd_data),
    .match_lines       (match_lines),
    .cm_match_ref_data (cm_match_ref_data),
    .status            (status)
  );

  // ==============================
  // Helpers
  // ==============================

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  function automatic int phase_count(input logic [3:0] m);
    int c;
    c = 0;
    for (int i = 0; i < 4; i++) begin
      if (m[i]) c++;
    end
    return c;
  endfunction

  // Match lines of a fault-free array for search number entry of a phase
  function automatic logic [`CAM_ENTRIES-1:0] expected_lines(input int phase, input int entry);
    logic [`CAM_ENTRIES-1:0] hit;
    hit        = '0;
    hit[entry] = 1'b1;
    case (phase)
      // Unique data, each value lives only at its own entry
      0: return hit;
      // Absent keys hit nothing
      1: return '0;
      // Common data, every entry hits
      2: return '1;
      // Hole at the searched entry only
      default: return ~hit;
    endcase
  endfunction

  // Inputs change 1 ns after the rising edge, outputs sampled there too
  task automatic next_cycle();
    @(posedge bist_clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    n_errors++;
    $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
  endtask

  task automatic report_failure(input string msg);
    n_errors++;
    $display("ERROR: %s at %0t", msg, $time);
  endtask

  task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
    cfg_wr_en = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    next_cycle();
    cfg_wr_en = 1'b0;
  endtask

  task automatic cam_write(input logic [3:0] addr, input logic [7:0] data);
    func_req         = '0;
    func_req.wr_en   = 1'b1;
    func_req.wr_addr = addr;
    func_req.wr_data = data;
    next_cycle();
    func_req          = '0;
    model_mem[addr]   = data;
    model_known[addr] = 1'b1;
  endtask

  // Match lines land two cycles after the search
  task automatic search_check(input logic [7:0] key);
    logic [`CAM_ENTRIES-1:0] expected;
    for (int i = 0; i < `CAM_ENTRIES; i++) begin
      expected[i] = model_known[i] && (model_mem[i] == key);
    end
    func_req          = '0;
    func_req.srch_en  = 1'b1;
    func_req.srch_key = key;
    next_cycle();
    func_req = '0;
    next_cycle();
    n_checks++;
    if (match_lines !== expected) report_mismatch("match_lines", match_lines, expected);
  endtask

  task automatic read_check(input logic [3:0] addr);
    func_req         = '0;
    func_req.rd_addr = addr;
    next_cycle();
    func_req = '0;
    next_cycle();
    n_checks++;
    if (rd_data !== model_mem[addr]) report_mismatch("rd_data", rd_data, model_mem[addr]);
  endtask

  // ==============================
  // Record handlers
  // ==============================

  // Full fill keeps the model exact, then extra writes and checks
  task automatic run_functional(input logic [7:0] n_wr, input logic [7:0] n_pairs);
    logic [7:0] a;
    logic [7:0] d;
    for (int i = 0; i < `CAM_ENTRIES; i++) begin
      take_bits(8, d);
      cam_write(i[3:0], d);
    end
    for (int i = 0; i < n_wr; i++) begin
      take_bits(4, a);
      take_bits(8, d);
      cam_write(a[3:0], d);
    end
    for (int i = 0; i < n_pairs; i++) begin
      take_bits(4, a);
      search_check(model_mem[a[3:0]]);
      take_bits(8, d);
      search_check(d);
      read_check(a[3:0]);
    end
  endtask

  task automatic run_bist(input logic [7:0] bg, input logic [3:0] mask,
                          input logic [7:0] exp_cnt);
    logic                    seen_low;
    logic                    finished;
    int                      cycles;
    logic [`CAM_ENTRIES-1:0] exp_vec [$];
    logic [`CAM_ENTRIES-1:0] exp_lines;
    logic [`CAM_ENTRIES-1:0] prev_match;
    logic [`CAM_ENTRIES-1:0] prev_ref;
    logic [7:0]              prev_cnt;
    if (exp_cnt != `CAM_ENTRIES * phase_count(mask)) begin
      report_failure("record compare count disagrees with its phase mask");
    end
    // Phases run in ascending order, one search per entry
    for (int p = 0; p < 4; p++) begin
      if (mask[p]) begin
        for (int i = 0; i < `CAM_ENTRIES; i++) exp_vec.push_back(expected_lines(p, i));
      end
    end
    cfg_write(`CFG_ADDR_BACKGROUND, bg);
    cfg_write(`CFG_ADDR_PHASE_MASK, {4'h0, mask});
    cfg_write(`CFG_ADDR_CTRL, 8'h01);
    // done from the previous run has to drop before the new rise counts
    seen_low = 1'b0;
    finished = 1'b0;
    cycles   = 0;
    while (!finished && cycles < RECORD_CYCLES) begin
      prev_match = match_lines;
      prev_ref   = cm_match_ref_data;
      prev_cnt   = status.cmp_cnt;
      next_cycle();
      cycles++;
      // Counter step marks the cycle that held a compare result
      if (status.cmp_cnt == prev_cnt + 8'd1) begin
        if (exp_vec.size() == 0) begin
          report_failure("BIST ran more compares than its phase mask allows");
        end else begin
          exp_lines = exp_vec.pop_front();
          n_checks += 2;
          if (prev_match !== exp_lines) begin
            report_mismatch("match_lines", prev_match, exp_lines);
          end
          if (prev_ref !== exp_lines) begin
            report_mismatch("cm_match_ref_data", prev_ref, exp_lines);
          end
        end
      end
      if (!status.done) begin
        seen_low = 1'b1;
      end else if (seen_low) begin
        finished = 1'b1;
      end
    end
    if (!finished) begin
      report_failure("BIST run did not raise done within the cycle limit");
    end else begin
      n_checks += 4;
      if (status.fail !== 1'b0) report_mismatch("status.fail", status.fail, 0);
      if (status.fail_cnt !== 8'd0) report_mismatch("status.fail_cnt", status.fail_cnt, 0);
      if (status.fail_addr !== '0) report_mismatch("status.fail_addr", status.fail_addr, 0);
      if (status.cmp_cnt !== exp_cnt) report_mismatch("status.cmp_cnt", status.cmp_cnt, exp_cnt);
    end
    // Unique phases leave bg^i, common and hole phases leave bg
    if (mask[0] || mask[1]) begin
      for (int i = 0; i < `CAM_ENTRIES; i++) model_mem[i] = bg ^ i[7:0];
      model_known = '1;
    end
    if (mask[2] || mask[3]) begin
      for (int i = 0; i < `CAM_ENTRIES; i++) model_mem[i] = bg;
      model_known = '1;
    end
    // Read data is array data again once compare mode is over
    for (int i = 0; i < `CAM_ENTRIES; i++) begin
      if (model_known[i]) read_check(i[3:0]);
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial begin
    reset       = 1'b1;
    cfg_wr_en   = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    func_req    = '0;
    lfsr        = 16'd95;
    model_known = '0;
    n_checks    = 0;
    n_errors    = 0;
    n_records   = 0;
    loaded      = 1'b0;
    for (int i = 0; i < MAX_RECORDS; i++) records[i] = '0;
    $readmemh("testbench/cam_bist_input.txt", records);
    // Kind 0 ends the record list
    while (n_records < MAX_RECORDS && records[n_records][31:28] != 4'h0) n_records++;
    loaded = 1'b1;
    if (n_records == 0) report_failure("no records were read from the input file");

    repeat (5) @(posedge bist_clk);
    #1;
    reset = 1'b0;
    n_checks++;
    if (status !== '0) report_mismatch("status", status, 0);

    for (int r = 0; r < n_records; r++) begin
      case (records[r][31:28])
        4'h1: run_functional(records[r][15:8], records[r][7:0]);
        4'h2: run_bist(records[r][23:16], records[r][11:8], records[r][7:0]);
        default: report_failure("input record has an unknown kind");
      endcase
    end

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Budget of 400 cycles per record plus one for reset
  initial begin
    wait (loaded === 1'b1);
    repeat ((n_records + 1) * RECORD_CYCLES) @(posedge bist_clk);
    $display("ERROR: watchdog expired after %0d cycles", (n_records + 1) * RECORD_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* testbench/cam_bist_input.txt */
// One record per line, 32-bit hex: kind[31:28] background[23:16] mask[11:8] count[7:0]
// Kind 1 functional: writes[15:8] search/read pairs[7:0]; kind 2 BIST run
10000810
205A0F40
10000408
20A50110
20A50210
20A50410
20A50810
10000206
203C0320
20C30620
20690520
20960C20
20110730
20000000
10000304
20FF0F40
20000F40
10000604

/* flist.f */
+incdir+common
common/cam_pkg.sv
common/bist_pkg.sv
cam/cam_array.sv
bist/bist_config_regs.sv
bist/bist_sequencer.sv
bist/bist_out_handler.sv
bist/bist_response_checker.sv
source/cam_bist_top.sv
testbench/tb_cam_bist.sv

/* Bender.yml */
package:
  name: cam_bist

sources:
  - include_dirs:
      - common
    files:
      - common/cam_pkg.sv
      - common/bist_pkg.sv
      - cam/cam_array.sv
      - bist/bist_config_regs.sv
      - bist/bist_sequencer.sv
      - bist/bist_out_handler.sv
      - bist/bist_response_checker.sv
      - source/cam_bist_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_cam_bist.sv
